// ==== src/ulpi_pkg.sv ====
// ulpi link layer constants, assumes a 60 MHz CLKOUT from the phy and a shortened phy reset
package ulpi_pkg;

	// command byte as a register write, code in the top two bits
	typedef struct packed {
		logic [1:0] code;	// 2'b10 for write
		logic [5:0] addr;	// immediate register address
	} reg_cmd_t;

	// command byte as a transmit, pid in the low nibble
	typedef struct packed {
		logic [1:0] code;	// 2'b01 for transmit
		logic [1:0] zero;	// must be 0
		logic [3:0] pid;	// usb pid, phy adds the check nibble
	} tx_cmd_t;

	// one tx byte, two readings
	typedef union packed {
		reg_cmd_t wr;
		tx_cmd_t  tx;
	} ulpi_cmd_u;

	// command codes
	localparam logic [1:0] CMD_TRANSMIT  = 2'd1;
	localparam logic [1:0] CMD_REG_WRITE = 2'd2;

	// register map, immediate addresses only
	localparam logic [5:0] REG_FUNC_CTRL = 6'h04;
	localparam logic [5:0] REG_OTG_CTRL  = 6'h0A;

	// otg off, peripheral mode
	localparam logic [7:0] OTG_CTRL_VAL  = 8'h00;
	// full speed, fs termination, normal op
	localparam logic [7:0] FUNC_CTRL_VAL = 8'h45;

	// phy reset hold, CLKOUT cycles
	// real boards want far longer than this
	localparam logic [15:0] PHY_RESET_CYCLES = 16'd64;

endpackage

// ==== src/usb_pkg.sv ====
// usb protocol constants for the first enumeration request only, no crc is generated or checked
package usb_pkg;

	// transmit pids, low nibble only
	localparam logic [3:0] PID_ACK   = 4'h2;
	localparam logic [3:0] PID_DATA1 = 4'hB;

	// DATA0 pid plus GET_DESCRIPTOR(device) setup bytes
	localparam logic [3:0] SETUP_LEN = 4'd9;
	localparam logic [0:8][7:0] SETUP_PATTERN = {
		8'hC3,	// DATA0
		8'h80,	// bmRequestType, device to host
		8'h06,	// GET_DESCRIPTOR
		8'h00, 8'h01,	// wValue, device descriptor
		8'h00, 8'h00,	// wIndex
		8'h40, 8'h00	// wLength 64
	};

	// IN token, addr 0 ep 0 with its crc5
	localparam logic [1:0] IN_LEN = 2'd3;
	localparam logic [0:2][7:0] IN_PATTERN = {8'h69, 8'h00, 8'h10};

	// crc16 bytes skipped after the setup data
	localparam logic [1:0] CRC_LEN = 2'd2;

	// device descriptor payload
	localparam logic [4:0] DESC_LEN = 5'd18;
	localparam logic [0:17][7:0] DEV_DESC = {
		8'h12, 8'h01,	// bLength, bDescriptorType
		8'h00, 8'h02,	// bcdUSB 2.00
		8'hFF, 8'hFF, 8'hFF,	// vendor specific class
		8'h08,	// bMaxPacketSize0
		8'h34, 8'h12,	// idVendor
		8'h78, 8'h56,	// idProduct
		8'h00, 8'h01,	// bcdDevice
		8'h00, 8'h00, 8'h00,	// no strings
		8'h01	// one configuration
	};

	// peer to arbiter
	typedef struct packed {
		logic       req;	// wants the bus
		logic [7:0] data;	// byte on offer, held until take
		logic       last;	// data is the final byte
	} tx_req_t;

	// arbiter to peer
	typedef struct packed {
		logic gnt;	// bus owned, until stp is done
		logic take;	// phy took data this cycle
	} tx_gnt_t;

endpackage

// ==== src/ulpi_phy_reset.sv ====
// phy reset runs once per reset, RST high for PHY_RESET_CYCLES after reset is released
`timescale 1ns/1ps

module ulpi_phy_reset import ulpi_pkg::*;
(
	input  logic CLKOUT,
	input  logic reset,
	output logic RST,
	output logic phy_ready
);

	logic [15:0] cnt;	// cycles since reset release

	always_ff @(posedge CLKOUT)
	begin
		if (!reset)
		begin
			cnt <= '0;
			RST <= 1'b1;	// hold phy in reset
		end
		else if (RST)
		begin
			if (cnt == PHY_RESET_CYCLES - 16'd1)
				RST <= 1'b0;	// release, never again until next reset
			else
				cnt <= cnt + 16'd1;
		end
	end

	// ready as soon as the pin drops
	assign phy_ready = ~RST;

endmodule

// ==== src/ulpi_tx_arbiter.sv ====
// single ulpi tx path for two peers, cfg peer wins, a grant lasts until its stp; DIR high stalls
`timescale 1ns/1ps

module ulpi_tx_arbiter import usb_pkg::*;
(
	input  logic       CLKOUT,
	input  logic       reset,
	input  logic       DIR,
	input  logic       NXT,
	input  tx_req_t    cfg_req,
	input  tx_req_t    rsp_req,
	output tx_gnt_t    cfg_gnt,
	output tx_gnt_t    rsp_gnt,
	output logic [7:0] data_out,
	output logic       data_oe,
	output logic       STP
);

	typedef enum logic [1:0] {
		A_IDLE,	// bus free for a new transfer
		A_SEND,	// forwarding owner bytes
		A_STOP	// one stp cycle
	} arb_state_t;

	arb_state_t state;
	logic       own_rsp;	// 0 cfg peer, 1 responder
	tx_req_t    cur;	// owner request
	logic       line_free;
	logic       take_now;

	assign cur       = own_rsp ? rsp_req : cfg_req;
	assign line_free = !DIR && !NXT;	// no rx, no pending nxt
	// phy latches the byte when nxt is high and we own the bus
	assign take_now  = (state == A_SEND) && NXT && !DIR;

	always_ff @(posedge CLKOUT)
	begin
		if (!reset)
		begin
			state   <= A_IDLE;
			own_rsp <= 1'b0;
		end
		else
		begin
			case (state)
				A_IDLE:
				begin
					if (line_free && (cfg_req.req || rsp_req.req))
					begin
						state   <= A_SEND;
						own_rsp <= !cfg_req.req;	// cfg first
					end
				end
				A_SEND:
				begin
					if (take_now && cur.last)
						state <= A_STOP;	// final byte gone
				end
				A_STOP:
				begin
					// phy has the bus, keep stp back until dir drops
					if (!DIR)
						state <= A_IDLE;
				end
				default: state <= A_IDLE;
			endcase
		end
	end

	// owner byte straight through, zero when idle or stopping
	assign data_out = (state == A_SEND) ? cur.data : 8'h00;
	assign STP      = (state == A_STOP) && !DIR;	// one cycle, never against dir
	assign data_oe  = ~DIR;	// link drives while phy does not

	// grant held through the stop cycle
	assign cfg_gnt.gnt  = (state != A_IDLE) && !own_rsp;
	assign cfg_gnt.take = take_now && !own_rsp;
	assign rsp_gnt.gnt  = (state != A_IDLE) && own_rsp;
	assign rsp_gnt.take = take_now && own_rsp;

endmodule

// ==== src/ulpi_reg_writer.sv ====
// writes OTG_CTRL then FUNC_CTRL once after phy reset, immediate addresses only, no readback
`timescale 1ns/1ps

module ulpi_reg_writer import ulpi_pkg::*, usb_pkg::*;
(
	input  logic    CLKOUT,
	input  logic    reset,
	input  logic    phy_ready,
	input  tx_gnt_t gnt,
	output tx_req_t req,
	output logic    cfg_done
);

	typedef enum logic [2:0] {
		W_IDLE,	// phy still in reset
		W_CMD,	// offering the command byte
		W_DATA,	// offering the register value
		W_STOP,	// arbiter sending stp
		W_DONE
	} wr_state_t;

	wr_state_t state;
	logic      second;	// 0 otg write, 1 func write
	ulpi_cmd_u cmd;

	always_ff @(posedge CLKOUT)
	begin
		if (!reset)
		begin
			state  <= W_IDLE;
			second <= 1'b0;
		end
		else
		begin
			case (state)
				W_IDLE: if (phy_ready) state <= W_CMD;
				W_CMD: if (gnt.take) state <= W_DATA;
				W_DATA: if (gnt.take) state <= W_STOP;	// req drops here
				W_STOP:
				begin
					// stp cycle, grant still ours
					if (gnt.gnt)
					begin
						state  <= second ? W_DONE : W_CMD;
						second <= 1'b1;
					end
				end
				default: state <= W_DONE;	// stays done
			endcase
		end
	end

	// command byte 8A or 84
	always_comb
	begin
		cmd         = '0;
		cmd.wr.code = CMD_REG_WRITE;
		cmd.wr.addr = second ? REG_FUNC_CTRL : REG_OTG_CTRL;
	end

	assign req.req  = (state == W_CMD) || (state == W_DATA);
	assign req.data = (state == W_CMD) ? cmd : (second ? FUNC_CTRL_VAL : OTG_CTRL_VAL);
	assign req.last = (state == W_DATA);
	assign cfg_done = (state == W_DONE);

endmodule

// ==== src/usb_rx_matcher.sv ====
// watches rx bytes for GET_DESCRIPTOR(device) setup and IN token, rx cmd bytes and crc are not decoded
`timescale 1ns/1ps

module usb_rx_matcher import usb_pkg::*;
(
	input  logic       CLKOUT,
	input  logic       reset,
	input  logic       DIR,
	input  logic       NXT,
	input  logic [7:0] data_in,
	output logic       setup_seen,
	output logic       in_seen
);

	logic       dir_q;	// dir last cycle
	logic       rx_byte;	// packet byte this cycle
	logic       dir_fall;
	logic [3:0] s_idx;	// next setup byte expected
	logic [1:0] i_idx;	// next in token byte expected
	logic [1:0] crc_left;	// crc bytes still to skip

	// turnaround is the first dir cycle, dir_q still low there
	assign rx_byte  = DIR && NXT && dir_q;
	assign dir_fall = !DIR && dir_q;

	always_ff @(posedge CLKOUT)
	begin
		if (!reset)
		begin
			dir_q      <= 1'b0;
			s_idx      <= '0;
			i_idx      <= '0;
			crc_left   <= '0;
			setup_seen <= 1'b0;
			in_seen    <= 1'b0;
		end
		else
		begin
			dir_q      <= DIR;
			setup_seen <= 1'b0;	// pulses only
			in_seen    <= 1'b0;
			if (dir_fall)
			begin
				s_idx <= '0;	// packet over, drop partials
				i_idx <= '0;
			end
			else if (rx_byte)
			begin
				// crc skip after a full setup match
				if (crc_left != 2'd0)
				begin
					crc_left <= crc_left - 2'd1;
					if (crc_left == 2'd1)
						setup_seen <= 1'b1;
				end
				// setup pattern
				if (data_in == SETUP_PATTERN[s_idx])
				begin
					if (s_idx == SETUP_LEN - 4'd1)
					begin
						s_idx    <= '0;
						crc_left <= CRC_LEN;	// two crc bytes follow
					end
					else
						s_idx <= s_idx + 4'd1;
				end
				else
					s_idx <= (data_in == SETUP_PATTERN[0]) ? 4'd1 : 4'd0;	// restart
				// in token
				if (data_in == IN_PATTERN[i_idx])
				begin
					if (i_idx == IN_LEN - 2'd1)
					begin
						i_idx   <= '0;
						in_seen <= 1'b1;
					end
					else
						i_idx <= i_idx + 2'd1;
				end
				else
					i_idx <= (data_in == IN_PATTERN[0]) ? 2'd1 : 2'd0;
			end
		end
	end

endmodule

// ==== src/usb_ctrl_responder.sv ====
// answers setup with ACK and the next IN with DATA1 device descriptor, no crc16 appended, no retries
`timescale 1ns/1ps

module usb_ctrl_responder import ulpi_pkg::*, usb_pkg::*;
(
	input  logic    CLKOUT,
	input  logic    reset,
	input  logic    cfg_done,
	input  logic    setup_seen,
	input  logic    in_seen,
	input  tx_gnt_t gnt,
	output tx_req_t req
);

	typedef enum logic [1:0] {
		P_WAIT_SETUP,
		P_SEND_ACK,	// single tx cmd byte
		P_WAIT_IN,
		P_SEND_DESC	// tx cmd then 18 payload bytes
	} rsp_phase_t;

	rsp_phase_t phase;
	logic [4:0] idx;	// 0 tx cmd, 1..18 descriptor bytes
	ulpi_cmd_u  cmd;
	logic       desc_last;

	assign desc_last = (idx == DESC_LEN);

	always_ff @(posedge CLKOUT)
	begin
		if (!reset)
		begin
			phase <= P_WAIT_SETUP;
			idx   <= '0;
		end
		else
		begin
			case (phase)
				P_WAIT_SETUP:
				begin
					// matches before configuration are noise
					if (cfg_done && setup_seen)
						phase <= P_SEND_ACK;
				end
				P_SEND_ACK:
				begin
					if (gnt.take)
						phase <= P_WAIT_IN;	// ack accepted
				end
				P_WAIT_IN:
				begin
					idx <= '0;
					if (in_seen)
						phase <= P_SEND_DESC;
				end
				P_SEND_DESC:
				begin
					if (gnt.take)
					begin
						idx <= idx + 5'd1;
						if (desc_last)
							phase <= P_WAIT_SETUP;	// ready for the next request
					end
				end
				default: phase <= P_WAIT_SETUP;
			endcase
		end
	end

	// tx cmd 42 for ack, 4B for data1
	always_comb
	begin
		cmd         = '0;
		cmd.tx.code = CMD_TRANSMIT;
		cmd.tx.zero = 2'b00;
		cmd.tx.pid  = (phase == P_SEND_ACK) ? PID_ACK : PID_DATA1;
	end

	always_comb
	begin
		req.req  = (phase == P_SEND_ACK) || (phase == P_SEND_DESC);
		req.last = (phase == P_SEND_ACK) || desc_last;
		if (phase == P_SEND_DESC && idx != 5'd0)
			req.data = DEV_DESC[idx - 5'd1];	// payload in order
		else
			req.data = cmd;
	end

endmodule

// ==== src/ulpi_link_top.sv ====
// ulpi link top, split data pins, the board wrapper ties data_out/data_oe/data_in to the pads
`timescale 1ns/1ps

module ulpi_link_top import usb_pkg::*;
(
	input  logic       CLKOUT,	// 60 MHz from the phy
	input  logic       reset,
	input  logic       DIR,
	input  logic       NXT,
	input  logic [7:0] data_in,
	output logic       RST,
	output logic       STP,
	output logic [7:0] data_out,
	output logic       data_oe
);

	logic    phy_ready;
	logic    cfg_done;
	logic    setup_seen;
	logic    in_seen;
	tx_req_t cfg_req;	// register writer side
	tx_gnt_t cfg_gnt;
	tx_req_t rsp_req;	// responder side
	tx_gnt_t rsp_gnt;

	ulpi_phy_reset u_phy_reset (
		.CLKOUT    (CLKOUT),
		.reset     (reset),
		.RST       (RST),
		.phy_ready (phy_ready)
	);

	ulpi_reg_writer u_reg_writer (
		.CLKOUT    (CLKOUT),
		.reset     (reset),
		.phy_ready (phy_ready),
		.gnt       (cfg_gnt),
		.req       (cfg_req),
		.cfg_done  (cfg_done)
	);

	usb_rx_matcher u_rx_matcher (
		.CLKOUT     (CLKOUT),
		.reset      (reset),
		.DIR        (DIR),
		.NXT        (NXT),
		.data_in    (data_in),
		.setup_seen (setup_seen),
		.in_seen    (in_seen)
	);

	usb_ctrl_responder u_responder (
		.CLKOUT     (CLKOUT),
		.reset      (reset),
		.cfg_done   (cfg_done),
		.setup_seen (setup_seen),
		.in_seen    (in_seen),
		.gnt        (rsp_gnt),
		.req        (rsp_req)
	);

	ulpi_tx_arbiter u_tx_arbiter (
		.CLKOUT   (CLKOUT),
		.reset    (reset),
		.DIR      (DIR),
		.NXT      (NXT),
		.cfg_req  (cfg_req),
		.rsp_req  (rsp_req),
		.cfg_gnt  (cfg_gnt),
		.rsp_gnt  (rsp_gnt),
		.data_out (data_out),
		.data_oe  (data_oe),
		.STP      (STP)
	);

endmodule

// ==== tests/ulpi_link_sva.sv ====
// bus rule assertions on the ulpi pins of ulpi_link_top, checked only outside reset
`timescale 1ns/1ps

module ulpi_link_sva
(
	input logic       CLKOUT,
	input logic       reset,
	input logic       DIR,
	input logic       NXT,
	input logic       RST,
	input logic       STP,
	input logic [7:0] data_out,
	input logic       data_oe
);

	// stp is a single cycle pulse
	a_stp_single: assert property (@(posedge CLKOUT) disable iff (!reset) STP |=> !STP)
		else $error("STP high for two consecutive cycles");

	// never stop while the phy owns the bus
	a_stp_dir: assert property (@(posedge CLKOUT) disable iff (!reset) !(STP && DIR))
		else $error("STP high while DIR high");

	// byte held until the phy takes it
	a_hold: assert property (@(posedge CLKOUT) disable iff (!reset)
		(data_oe && data_out != 8'h00 && !NXT) |=> $stable(data_out))
		else $error("data_out changed while stalled");

	// phy reset happens once
	a_rst_once: assert property (@(posedge CLKOUT) disable iff (!reset) !RST |=> !RST)
		else $error("RST rose again after release");

endmodule

bind ulpi_link_top ulpi_link_sva u_sva (
	.CLKOUT   (CLKOUT),
	.reset    (reset),
	.DIR      (DIR),
	.NXT      (NXT),
	.RST      (RST),
	.STP      (STP),
	.data_out (data_out),
	.data_oe  (data_oe)
);

// ==== tests/tb_ulpi_link.sv ====
// directed tests on ulpi_link_top, phy model is inline per task, rx packets carry no real crc
`timescale 1ns/1ps

module tb_ulpi_link import ulpi_pkg::*;
();

	// cycle budgets per test, also used as per task timeouts
	localparam int RESET_BUDGET    = int'(PHY_RESET_CYCLES) + 20;
	localparam int CFG_BUDGET      = 100;
	localparam int STALL_BUDGET    = 300;
	localparam int ACK_BUDGET      = 120;
	localparam int DESC_BUDGET     = 200;
	localparam int MISMATCH_BUDGET = 260;
	localparam int BUDGET_SUM      = 2 * RESET_BUDGET + CFG_BUDGET + STALL_BUDGET
		+ 2 * ACK_BUDGET + DESC_BUDGET + MISMATCH_BUDGET;
	localparam int WATCHDOG_NS     = (int'(PHY_RESET_CYCLES) + BUDGET_SUM) * 10;
	localparam int STP_MARK        = 'h100;	// stands for an stp pulse in a byte sequence

	logic       CLKOUT;
	logic       reset;
	logic       DIR;
	logic       NXT;
	logic [7:0] data_in;
	logic       RST;
	logic       STP;
	logic [7:0] data_out;
	logic       data_oe;

	int          value_errors;	// wrong values seen
	int          other_errors;	// timeouts, protocol slips
	int unsigned seed;
	int          got[$];	// bytes taken by the phy, STP_MARK for stp
	int          exp[$];
	logic [7:0]  rx_q[$];	// next packet for the phy to send

	ulpi_link_top DUT (
		.CLKOUT   (CLKOUT),
		.reset    (reset),
		.DIR      (DIR),
		.NXT      (NXT),
		.data_in  (data_in),
		.RST      (RST),
		.STP      (STP),
		.data_out (data_out),
		.data_oe  (data_oe)
	);

	always #5 CLKOUT = ~CLKOUT;	// 100 MHz stands in for 60 MHz

	// reset for 5 cycles, then count RST high cycles
	task automatic reset_and_check_rst();
		int high_cycles;
		bit fell;
		high_cycles = 0;
		fell        = 1'b0;
		@(posedge CLKOUT);
		reset <= 1'b0;
		DIR   <= 1'b0;
		NXT   <= 1'b0;
		repeat (5) @(posedge CLKOUT);
		reset <= 1'b1;
		for (int c = 0; c < RESET_BUDGET && !fell; c++)
		begin
			@(posedge CLKOUT);
			if (STP !== 1'b0)
			begin
				value_errors++;
				$display("Fail STP got %h expected %h", STP, 1'b0);
			end
			if (data_out !== 8'h00)
			begin
				value_errors++;
				$display("Fail data_out got %h expected %h", data_out, 8'h00);
			end
			if (RST === 1'b1)
				high_cycles++;
			else
				fell = 1'b1;	// released
		end
		if (!fell)
		begin
			other_errors++;
			$display("RST was never released after reset");
		end
		else if (high_cycles != int'(PHY_RESET_CYCLES))
		begin
			value_errors++;
			$display("Fail RST high cycles got %h expected %h", high_cycles, PHY_RESET_CYCLES);
		end
	endtask

	// phy tx side, takes bytes with NXT until n_xfers stp pulses are seen
	task automatic capture_tx(input int n_xfers, input bit stalls, input bit dir_burst,
		input int budget);
		bit         in_tx;
		bit         prev_stall;
		bit         prev_stp;
		bit         burst_done;
		logic [7:0] prev_data;
		int         done_xfers;
		int         takes;
		int         burst_left;
		int         cycles;
		in_tx      = 1'b0;
		prev_stall = 1'b0;
		prev_stp   = 1'b0;
		burst_done = 1'b0;
		prev_data  = 8'h00;
		done_xfers = 0;
		takes      = 0;
		burst_left = 0;
		cycles     = 0;
		got.delete();
		while (done_xfers < n_xfers && cycles < budget)
		begin
			@(posedge CLKOUT);
			cycles++;
			// values here are the ones settled in the cycle just ended
			if (data_oe !== !DIR)
			begin
				value_errors++;
				$display("Fail data_oe got %h expected %h", data_oe, !DIR);
			end
			if (STP && prev_stp)
			begin
				other_errors++;
				$display("STP stayed high for two cycles");
			end
			if (in_tx && STP)
			begin
				got.push_back(STP_MARK);
				in_tx = 1'b0;
				done_xfers++;
			end
			else if (in_tx && NXT && !DIR)
			begin
				got.push_back(int'(data_out));	// phy takes the byte
				takes++;
			end
			else if (in_tx && prev_stall && data_out !== prev_data)
			begin
				value_errors++;
				$display("Fail data_out got %h expected %h", data_out, prev_data);
			end
			else if (!in_tx && STP)
			begin
				other_errors++;
				$display("STP pulsed outside a transfer");
			end
			else if (!in_tx && !DIR && data_out != 8'h00)
				in_tx = 1'b1;	// command byte marks a new transfer
			prev_stall = in_tx && !(NXT && !DIR);
			prev_data  = data_out;
			prev_stp   = STP;
			// one rx burst with NXT low, during the first write data byte
			if (dir_burst && !burst_done && takes == 1 && in_tx)
			begin
				burst_left = 3;
				burst_done = 1'b1;
			end
			if (burst_left > 0)
			begin
				DIR <= 1'b1;
				NXT <= 1'b0;
				burst_left--;
			end
			else
			begin
				DIR <= 1'b0;
				if (!in_tx)
					NXT <= 1'b0;	// keeps the line free
				else if (stalls)
					NXT <= ($urandom_range(3, 0) != 0);	// about one stall in four
				else
					NXT <= 1'b1;
			end
		end
		if (done_xfers < n_xfers)
		begin
			other_errors++;
			$display("transmit did not finish within %0d cycles", budget);
		end
	endtask

	task automatic compare_tx(input string what);
		if (got.size() != exp.size())
		begin
			value_errors++;
			$display("Fail data_out %s byte count got %h expected %h", what, got.size(),
				exp.size());
		end
		for (int k = 0; k < got.size() && k < exp.size(); k++)
		begin
			if (got[k] != exp[k])
			begin
				value_errors++;
				$display("Fail data_out %s byte %0d got %h expected %h", what, k, got[k], exp[k]);
			end
		end
	endtask

	// phy rx side, turnaround cycle then one byte per cycle
	task automatic send_rx_packet();
		@(posedge CLKOUT);
		DIR <= 1'b1;
		NXT <= 1'b0;
		foreach (rx_q[k])
		begin
			@(posedge CLKOUT);
			NXT     <= 1'b1;
			data_in <= rx_q[k];
		end
		@(posedge CLKOUT);
		DIR     <= 1'b0;	// bus back to the link
		NXT     <= 1'b0;
		data_in <= 8'h00;
	endtask

	// GET_DESCRIPTOR(device) setup plus two crc bytes, bad_pos flips one byte
	task automatic load_setup(input int bad_pos);
		logic [7:0] pattern [0:8];
		pattern = '{8'hC3, 8'h80, 8'h06, 8'h00, 8'h01, 8'h00, 8'h00, 8'h40, 8'h00};
		rx_q.delete();
		for (int k = 0; k < 9; k++)
			rx_q.push_back((k == bad_pos) ? (pattern[k] ^ 8'h01) : pattern[k]);
		rx_q.push_back(8'($urandom_range(255, 0)));	// crc, skipped by the dut
		rx_q.push_back(8'($urandom_range(255, 0)));
	endtask

	// OTG_CTRL then FUNC_CTRL writes, optionally under back-pressure
	task automatic test_config(input bit pressure);
		exp.delete();
		exp.push_back('h8A);	// reg write, addr 0A
		exp.push_back('h00);
		exp.push_back(STP_MARK);
		exp.push_back('h84);	// reg write, addr 04
		exp.push_back('h45);
		exp.push_back(STP_MARK);
		capture_tx(2, pressure, pressure, pressure ? STALL_BUDGET : CFG_BUDGET);
		compare_tx(pressure ? "config stalled" : "config");
	endtask

	task automatic test_ack();
		load_setup(-1);
		send_rx_packet();
		exp.delete();
		exp.push_back('h42);	// transmit, PID ACK
		exp.push_back(STP_MARK);
		capture_tx(1, 1'b0, 1'b0, ACK_BUDGET);
		compare_tx("ack");
	endtask

	task automatic test_descriptor();
		logic [7:0] desc [0:17];
		desc = '{8'h12, 8'h01, 8'h00, 8'h02, 8'hFF, 8'hFF, 8'hFF, 8'h08, 8'h34,
			8'h12, 8'h78, 8'h56, 8'h00, 8'h01, 8'h00, 8'h00, 8'h00, 8'h01};
		rx_q.delete();
		rx_q.push_back(8'h69);	// IN token, addr 0 ep 0
		rx_q.push_back(8'h00);
		rx_q.push_back(8'h10);
		send_rx_packet();
		exp.delete();
		exp.push_back('h4B);	// transmit, PID DATA1
		foreach (desc[k])
			exp.push_back(int'(desc[k]));
		exp.push_back(STP_MARK);
		capture_tx(1, 1'b1, 1'b0, DESC_BUDGET);
		compare_tx("descriptor");
	endtask

	// wrong bRequest byte, nothing may go out
	task automatic test_mismatch();
		bit seen;
		seen = 1'b0;
		load_setup(2);
		send_rx_packet();
		for (int c = 0; c < 100; c++)
		begin
			@(posedge CLKOUT);
			if (!seen && (STP || data_out != 8'h00))
			begin
				seen = 1'b1;
				other_errors++;
				$display("transmit started after a setup packet with a wrong byte");
			end
		end
		test_ack();	// responder still in wait-setup
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the tests did not complete");
		$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		CLKOUT       = 1'b0;
		reset        = 1'b0;
		DIR          = 1'b0;
		NXT          = 1'b0;
		data_in      = 8'h00;
		value_errors = 0;
		other_errors = 0;
		seed         = $urandom(32'hd650e11a);
		reset_and_check_rst();
		test_config(1'b0);
		reset_and_check_rst();	// config runs once per reset
		test_config(1'b1);
		test_ack();
		test_descriptor();
		test_mismatch();
		$display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== flist.f ====
src/ulpi_pkg.sv
src/usb_pkg.sv
src/ulpi_phy_reset.sv
src/ulpi_tx_arbiter.sv
src/ulpi_reg_writer.sv
src/usb_rx_matcher.sv
src/usb_ctrl_responder.sv
src/ulpi_link_top.sv
tests/ulpi_link_sva.sv
tests/tb_ulpi_link.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_ulpi_link
FLIST     := flist.f
BUILD     := obj_dir
LOG       := sim.log
BIN       := $(BUILD)/V$(TOP)
SOURCES   := $(wildcard src/*.sv tests/*.sv)

.PHONY: all run lint clean

all: run

$(BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation failed"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)
